// ==== test/core_testdata.txt ====
# I = program words from pc 0, P = pc at each retired cycle, S = store address then data
# 1e002e23 stores to 0x1fc and sits only in slots that a jump must skip
I 10102023                                # sw x1 before any write
I ff900093 00300113                       # x1 = -7, x2 = 3
I 002081b3 10302223 402081b3 10302423     # add, sub
I 002091b3 10302623 0020a1b3 10302823     # sll, slt
I 0020b1b3 10302a23 0020c1b3 10302c23     # sltu, xor
I 0020d1b3 10302e23 4020d1b3 12302023     # srl, sra
I 0020e1b3 12302223 0020f1b3 12302423     # or, and
I 00409193 12302623 4020d193 12302823     # slli 4, srai 2
I fff13193 12302a23                       # sltiu x2 < -1
I deadc237 eef20213 12402c23              # lui plus addi
I 00210463 1e002e23 00208463              # beq taken, not taken
I 00209463 1e002e23 00211463              # bne
I 0020c463 1e002e23 00114463              # blt
I 00115463 1e002e23 0020d463              # bge
I 00116463 1e002e23 0020e463              # bltu
I 0020f463 1e002e23 00117463              # bgeu
I 008002ef 1e002e23 12502e23              # jal x5 +8, store the link
I 00500013 14002023                       # addi to x0, store x0
I 00002083 14102223                       # lw is unsupported, x1 kept
P 00000000 00000004 00000008 0000000c 00000010 00000014 00000018 0000001c
P 00000020 00000024 00000028 0000002c 00000030 00000034 00000038 0000003c
P 00000040 00000044 00000048 0000004c 00000050 00000054 00000058 0000005c
P 00000060 00000064 00000068 0000006c 00000070 00000074 00000078 0000007c
P 00000080 00000088 0000008c 00000094 00000098 000000a0 000000a4 000000ac
P 000000b0 000000b8 000000bc 000000c4 000000c8 000000d0 000000d4 000000d8
P 000000dc 000000e0
S 00000100 00000000  00000104 fffffffc    # reset, add
S 00000108 fffffff6  0000010c ffffffc8    # sub, sll
S 00000110 00000001  00000114 00000000    # slt, sltu
S 00000118 fffffffa  0000011c 1fffffff    # xor, srl
S 00000120 ffffffff  00000124 fffffffb    # sra, or
S 00000128 00000001  0000012c ffffff90    # and, slli
S 00000130 fffffffe  00000134 00000001    # srai, sltiu
S 00000138 deadbeef  0000013c 000000cc    # lui plus addi, jal link
S 00000140 00000000  00000144 fffffff9    # x0, x1 after the unsupported word

// ==== verilog.f ====
+incdir+logic
logic/riscv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/core_ifs.sv
logic/alu.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/pc_unit.sv
logic/core_top.sv
test/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/riscv_isa_pkg.sv
      - logic/core_ctrl_pkg.sv
      - logic/core_ifs.sv
      - logic/alu.sv
      - logic/instr_decoder.sv
      - logic/reg_file.sv
      - logic/exec_unit.sv
      - logic/pc_unit.sv
      - logic/core_top.sv
  - target: test
    files:
      - test/core_tb.sv

// ==== test/core_tb.sv ====
`timescale 1ns/10ps

module core_tb;
    import riscv_isa_pkg::*;

    localparam int     CLK_PERIOD   = 20;            // ns
    localparam int     RESET_CYCLES = 2;
    localparam int     WD_MARGIN    = 20;            // spare cycles for the watchdog
    localparam instr_t NOP_INSTR    = 32'h0000_0013; // addi x0, x0, 0

    logic   CLK;
    logic   RESET;
    instr_t instr_i;
    word_t  pc_o;
    logic   mem_req_o;
    logic   mem_we_o;
    word_t  mem_addr_o;
    word_t  mem_wdata_o;

    instr_t imem [$];           // program with word i at pc 4*i
    word_t  pc_exp [$];         // pc seen at each falling edge
    word_t  store_addr_exp [$];
    word_t  store_data_exp [$];

    int pc_errors    = 0;
    int store_errors = 0;
    int other_errors = 0;
    int store_idx    = 0;       // next expected store
    int wd_cycles    = 0;
    bit data_ok      = 1'b0;

    core_top i_core_top (
        .CLK         (CLK),
        .RESET       (RESET),
        .instr_i     (instr_i),
        .pc_o        (pc_o),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_pc(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            pc_errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            store_errors++;
        end
    endtask

    // instruction memory model that returns a nop outside the program
    function automatic instr_t fetch_instr(input word_t pc);
        word_t idx;
        idx = pc >> 2;
        if (pc[1:0] == 2'b00 && idx < imem.size()) begin
            return imem[idx];
        end
        return NOP_INSTR; // also covers an unknown pc
    endfunction

    //////////////////////////////////////////////////
    // test data holds a section tag followed by hex tokens
    //////////////////////////////////////////////////
    task automatic load_testdata(output bit ok);
        int    fd;
        int    ch;
        string tok;
        word_t val;
        byte   mode;
        bit    have_addr;
        fd        = $fopen("test/core_testdata.txt", "r");
        ok        = 1'b0;
        mode      = "-";
        have_addr = 1'b0;
        if (fd == 0) begin
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == "#") begin          // comment runs to end of line
                ch = $fgetc(fd);
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (tok == "I" || tok == "P" || tok == "S") begin
                mode = tok.getc(0);
            end else if ($sscanf(tok, "%h", val) != 1) begin
                $display("test data holds a token that is not a hex word: %s", tok);
                other_errors++;
            end else if (mode == "I") begin
                imem.push_back(val);
            end else if (mode == "P") begin
                pc_exp.push_back(val);
            end else if (mode == "S") begin
                if (have_addr) begin
                    store_data_exp.push_back(val);
                end else begin
                    store_addr_exp.push_back(val);
                end
                have_addr = ~have_addr;            // address, data, address ...
            end else begin
                $display("test data has a value before any section tag");
                other_errors++;
            end
        end
        $fclose(fd);
        if (have_addr) begin
            $display("test data ends with a store address that has no data");
            other_errors++;
        end
        ok = (imem.size() > 0) && (pc_exp.size() > 0);
    endtask

    // store port sampled at the edge that retires the sw
    always @(posedge CLK) begin
        if (!RESET && mem_req_o && mem_we_o) begin
            if (store_idx < store_data_exp.size()) begin
                check_word($sformatf("store %0d addr", store_idx),
                           store_addr_exp[store_idx], mem_addr_o);
                check_word($sformatf("store %0d data", store_idx),
                           store_data_exp[store_idx], mem_wdata_o);
            end else begin
                $display("the core made a store beyond the expected ones, addr %h data %h",
                         mem_addr_o, mem_wdata_o);
                other_errors++;
            end
            store_idx++;
        end else if (!RESET && (mem_req_o !== 1'b0 || mem_we_o !== 1'b0)) begin
            // request and write enable must rise together and only for sw
            $display("store port request %b and write enable %b do not match",
                     mem_req_o, mem_we_o);
            other_errors++;
        end
    end

    // drive the program and trace the pc with one retire per cycle
    task automatic run_program();
        for (int k = 0; k < pc_exp.size(); k++) begin
            if (k > 0) begin
                @(negedge CLK);
            end
            check_pc($sformatf("pc step %0d", k), pc_exp[k], pc_o);
            instr_i = fetch_instr(pc_o);
        end
        @(posedge CLK); // last instruction retires here
        #1;
    endtask

    initial begin
        bit ok;
        CLK     = 1'b0;
        RESET   = 1'b1;
        instr_i = NOP_INSTR;   // keeps the store port quiet in reset
        load_testdata(ok);
        if (!ok) begin
            $display("test data file is missing or has no program or pc trace");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            wd_cycles = pc_exp.size() + WD_MARGIN;
            data_ok   = 1'b1;
            repeat (RESET_CYCLES) @(posedge CLK);
            @(negedge CLK);
            RESET = 1'b0;
            run_program();
            if (store_idx < store_data_exp.size()) begin
                $display("the core made %0d stores, %0d were expected",
                         store_idx, store_data_exp.size());
                other_errors++;
            end
            $display("errors: pc %0d, store %0d, other %0d",
                     pc_errors, store_errors, other_errors);
            if (pc_errors + store_errors + other_errors == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

    // watchdog armed once the trace length is known
    initial begin
        wait (data_ok);
        #(wd_cycles * CLK_PERIOD);
        $display("run did not finish within %0d cycles", wd_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== logic/core_top.sv ====
`timescale 1ns/10ps

module core_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  riscv_isa_pkg::instr_t instr_i,     // instruction at pc_o
    output riscv_isa_pkg::word_t  pc_o,        // fetch address
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output riscv_isa_pkg::word_t  mem_addr_o,
    output riscv_isa_pkg::word_t  mem_wdata_o
);

    ctrl_if ctrl ();
    rf_if   rf ();

    logic branch_taken;

    assign rf.we = ctrl.rf_we; // decoder owns the write enable

    instr_decoder i_instr_decoder (
        .instr_i (instr_i),
        .ctrl    (ctrl),
        .rf      (rf)
    );

    reg_file i_reg_file (
        .CLK   (CLK),
        .RESET (RESET),
        .rf    (rf)
    );

    exec_unit i_exec_unit (
        .pc_i           (pc_o),
        .ctrl           (ctrl),
        .rf             (rf),
        .branch_taken_o (branch_taken),
        .mem_req_o      (mem_req_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o)
    );

    pc_unit i_pc_unit (
        .CLK            (CLK),
        .RESET          (RESET),
        .ctrl           (ctrl),
        .branch_taken_i (branch_taken),
        .pc_o           (pc_o)
    );

endmodule

// ==== logic/pc_unit.sv ====
`timescale 1ns/10ps
`include "core_macros.svh"

module pc_unit (
    input  logic                 CLK,
    input  logic                 RESET,
    ctrl_if.pc                   ctrl,
    input  logic                 branch_taken_i,
    output riscv_isa_pkg::word_t pc_o
);
    import riscv_isa_pkg::*;

    word_t pc_q;
    word_t pc_step; // imm for jumps and 4 otherwise

    // jal and taken branches are both pc relative
    assign pc_step = (ctrl.jal || branch_taken_i) ? ctrl.imm : word_t'(`INSTR_BYTES);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc_q <= word_t'(`RESET_PC);
        end else begin
            pc_q <= pc_q + pc_step; // one instruction retires per edge
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/10ps
`include "core_macros.svh"

module exec_unit (
    input  riscv_isa_pkg::word_t pc_i,
    ctrl_if.exe                  ctrl,
    rf_if.exe                    rf,
    output logic                 branch_taken_o,
    output logic                 mem_req_o,
    output logic                 mem_we_o,
    output riscv_isa_pkg::word_t mem_addr_o,
    output riscv_isa_pkg::word_t mem_wdata_o
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_result;
    logic  alu_flag;

    ////////////////////////////////////////////////////
    // operand muxes
    ////////////////////////////////////////////////////
    always_comb begin
        case (ctrl.op_a_sel)
            OP_A_PC:   op_a = pc_i;
            OP_A_ZERO: op_a = '0;
            default:   op_a = rf.rd1;
        endcase
    end

    always_comb begin
        case (ctrl.op_b_sel)
            OP_B_IMM:  op_b = ctrl.imm;
            OP_B_FOUR: op_b = word_t'(`INSTR_BYTES);
            default:   op_b = rf.rd2;
        endcase
    end

    alu i_alu (
        .op_i     (ctrl.alu_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_result),
        .flag_o   (alu_flag)
    );

    assign rf.wd          = alu_result;               // alu only since there is no load path
    assign branch_taken_o = ctrl.branch & alu_flag;

    // request and write enable go together since only sw reaches memory
    assign mem_req_o   = ctrl.mem_req;
    assign mem_we_o    = ctrl.mem_req;
    assign mem_addr_o  = alu_result;                  // rs1 + imm_s
    assign mem_wdata_o = rf.rd2;

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/10ps
`include "core_macros.svh"

module reg_file (
    input logic CLK,
    input logic RESET,
    rf_if.rf    rf
);
    import riscv_isa_pkg::*;

    word_t regs [`REG_COUNT]; // x0 .. x31

    // both reads are asynchronous
    assign rf.rd1 = regs[rf.ra1];
    assign rf.rd2 = regs[rf.ra2];

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.we && rf.wa != '0) begin // x0 stays zero
            regs[rf.wa] <= rf.wd;
        end
    end

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder (
    input  riscv_isa_pkg::instr_t instr_i, // instruction fetched at pc
    ctrl_if.dec                   ctrl,
    rf_if.dec                     rf
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    opcode_e opcode;
    funct3_t funct3;
    funct7_t funct7;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_j;
    word_t   imm_u;
    alu_op_e arith_op;  // op for OP / OP_IMM
    alu_op_e cmp_op;    // op for BRANCH
    logic    cmp_valid; // funct3 names a real branch

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // register fields sit at fixed bits in every format
    assign rf.ra1 = instr_i[19:15];
    assign rf.ra2 = instr_i[24:20];
    assign rf.wa  = instr_i[11:7];

    ////////////////////////////////////////////////////
    // immediates sign extended from bit 31
    ////////////////////////////////////////////////////
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0}; // lower bits zero

    // funct3 selects the alu op and bit 30 picks sub (R-type only) or sra/srai
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    // funct3 010 and 011 name no branch condition
    always_comb begin
        cmp_valid = 1'b1;
        case (branch_f3_e'(funct3))
            BEQ:  cmp_op = ALU_EQ;
            BNE:  cmp_op = ALU_NE;
            BLT:  cmp_op = ALU_LT;
            BGE:  cmp_op = ALU_GE;
            BLTU: cmp_op = ALU_LTU;
            BGEU: cmp_op = ALU_GEU;
            default: begin
                cmp_op    = ALU_EQ;
                cmp_valid = 1'b0; // falls through as pc + 4
            end
        endcase
    end

    ////////////////////////////////////////////////////
    // main control
    ////////////////////////////////////////////////////
    always_comb begin
        // defaults give a nop that writes and stores nothing
        ctrl.alu_op   = ALU_ADD;
        ctrl.op_a_sel = OP_A_RS1;
        ctrl.op_b_sel = OP_B_RS2;
        ctrl.imm      = imm_i;
        ctrl.rf_we    = 1'b0;
        ctrl.mem_req  = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.jal      = 1'b0;
        case (opcode)
            OP: begin
                ctrl.alu_op = arith_op;
                ctrl.rf_we  = 1'b1;
            end
            OP_IMM: begin
                ctrl.alu_op   = arith_op;
                ctrl.op_b_sel = OP_B_IMM; // shamt is imm_i[4:0]
                ctrl.rf_we    = 1'b1;
            end
            LUI: begin
                ctrl.op_a_sel = OP_A_ZERO; // 0 + imm_u
                ctrl.op_b_sel = OP_B_IMM;
                ctrl.imm      = imm_u;
                ctrl.rf_we    = 1'b1;
            end
            STORE: begin
                ctrl.op_b_sel = OP_B_IMM; // address = rs1 + imm_s
                ctrl.imm      = imm_s;
                ctrl.mem_req  = (funct3 == F3_SW); // sb / sh ignored
            end
            BRANCH: begin
                ctrl.alu_op = cmp_op; // rs1 vs rs2
                ctrl.imm    = imm_b;  // target offset for pc_unit
                ctrl.branch = cmp_valid;
            end
            JAL: begin
                ctrl.op_a_sel = OP_A_PC; // link = pc + 4
                ctrl.op_b_sel = OP_B_FOUR;
                ctrl.imm      = imm_j;
                ctrl.rf_we    = 1'b1;
                ctrl.jal      = 1'b1;
            end
            default: ; // unsupported opcodes keep the defaults
        endcase
    end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/10ps
`include "core_macros.svh"

module alu (
    input  core_ctrl_pkg::alu_op_e op_i,
    input  riscv_isa_pkg::word_t   a_i,
    input  riscv_isa_pkg::word_t   b_i,
    output riscv_isa_pkg::word_t   result_o,
    output logic                   flag_o    // compare outcome
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;  // signed a < b
    logic               lt_u;  // unsigned a < b

    assign shamt = b_i[SHAMT_W-1:0]; // upper bits of b ignored
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        result_o = '0;
        flag_o   = 1'b0;
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SLT:  result_o = word_t'(lt_s);
            ALU_SLTU: result_o = word_t'(lt_u);
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt); // sign fill
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            ALU_EQ:   flag_o   = (a_i == b_i);
            ALU_NE:   flag_o   = (a_i != b_i);
            ALU_LT:   flag_o   = lt_s;
            ALU_GE:   flag_o   = ~lt_s;
            ALU_LTU:  flag_o   = lt_u;
            ALU_GEU:  flag_o   = ~lt_u;
            default:  ;
        endcase
    end

endmodule

// ==== logic/core_ifs.sv ====
`timescale 1ns/10ps

// decoded control of the current instruction
interface ctrl_if;
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    word_t     imm;       // immediate already sign extended and shifted
    logic      rf_we;     // write rd this cycle
    logic      mem_req;   // sw in flight
    logic      branch;    // conditional branch decided by the alu flag
    logic      jal;       // unconditional jump

    modport dec (output alu_op, op_a_sel, op_b_sel, imm, rf_we, mem_req, branch, jal);
    modport exe (input alu_op, op_a_sel, op_b_sel, imm, mem_req, branch);
    modport pc  (input imm, jal);
endinterface

// register file access
interface rf_if;
    import riscv_isa_pkg::*;

    reg_addr_t ra1;
    reg_addr_t ra2;
    reg_addr_t wa;
    word_t     wd;
    logic      we;
    word_t     rd1;
    word_t     rd2;

    modport dec (output ra1, ra2, wa);
    modport exe (input rd1, rd2, output wd);
    modport rf  (input ra1, ra2, wa, wd, we, output rd1, rd2);
endinterface

// ==== logic/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

    // arithmetic ops give result_o and compares give flag_o
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_EQ   = 4'd10,
        ALU_NE   = 4'd11,
        ALU_LT   = 4'd12,
        ALU_GE   = 4'd13,
        ALU_LTU  = 4'd14,
        ALU_GEU  = 4'd15
    } alu_op_e;

    // operand a source
    typedef enum logic [1:0] {
        OP_A_RS1  = 2'd0,
        OP_A_PC   = 2'd1, // jal link address
        OP_A_ZERO = 2'd2  // lui
    } op_a_sel_e;

    // operand b source
    typedef enum logic [1:0] {
        OP_B_RS2  = 2'd0,
        OP_B_IMM  = 2'd1,
        OP_B_FOUR = 2'd2  // pc + 4 for the link register
    } op_b_sel_e;

endpackage

// ==== logic/riscv_isa_pkg.sv ====
`include "core_macros.svh"

package riscv_isa_pkg;

    ////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////
    typedef logic [`XLEN-1:0]       word_t;     // data, address or immediate
    typedef logic [31:0]            instr_t;    // raw instruction of 32 bits
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t; // rs1 / rs2 / rd index
    typedef logic [2:0]             funct3_t;
    typedef logic [6:0]             funct7_t;

    // anything outside these major opcodes retires as a nop
    typedef enum logic [6:0] {
        OP     = 7'b0110011, // R-type alu
        OP_IMM = 7'b0010011, // I-type alu and shifts
        LUI    = 7'b0110111,
        STORE  = 7'b0100011, // only sw is executed
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // funct3 of the conditional branches
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100, // signed
        BGE  = 3'b101, // signed
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_f3_e;

    localparam funct3_t F3_SW = 3'b010; // word store

endpackage

// ==== logic/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and address width
`define XLEN        32

// integer register file geometry
`define REG_COUNT   32
`define REG_ADDR_W  5

// fetch side
`define RESET_PC    0   // first fetch address after reset
`define INSTR_BYTES 4   // sequential pc step

`endif
